// ==== design/gpio_cfg.svh ====
// Fixed configuration for the GPIO subsystem.
// Pin count, register address width and the register map.
// Included by the packages and by any module that decodes addresses.

`ifndef GPIO_CFG_SVH
`define GPIO_CFG_SVH

// --------------------
// widths

`define GPIO_WIDTH            16      // pins, also the register data width
`define GPIO_ADDR_WIDTH       6       // register bus address width

// --------------------
// register map

`define GPIO_ADDR_DIRECTION   6'h04   // 1 = input, 0 = output
`define GPIO_ADDR_OUT_ENABLE  6'h08   // output driver enable
`define GPIO_ADDR_OUT_VALUE   6'h0C   // value driven on output pins
`define GPIO_ADDR_IN_VALUE    6'h10   // synchronised pin value, read only
`define GPIO_ADDR_INT_STATUS  6'h20   // sticky rising edge status, clear on read

`endif

// ==== design/gpio_bus_pkg.sv ====
// Types for the shared GPIO register bus.
// Used by the arbiter, the scanner, the register block and the top level.

`include "gpio_cfg.svh"

package gpio_bus_pkg;

  // register address and data words
  typedef logic [`GPIO_ADDR_WIDTH-1:0] gpio_addr_t;
  typedef logic [`GPIO_WIDTH-1:0]      gpio_data_t;

  // which master holds the bus
  // also remembers the owner of an outstanding read
  typedef enum logic
  {
    OWNER_HOST = 1'b0,   // external host port
    OWNER_SCAN = 1'b1    // interrupt scanner
  } bus_owner_t;

endpackage

// ==== design/gpio_pin_pkg.sv ====
// Types for the pin side of the GPIO subsystem.
// Pin vectors and the interrupt scanner state machine.

`include "gpio_cfg.svh"

package gpio_pin_pkg;

  // one bit per pin
  typedef logic [`GPIO_WIDTH-1:0] pin_vec_t;

  // interrupt scanner FSM
  typedef enum logic [1:0]
  {
    SCAN_IDLE = 2'b00,   // waiting for pending status
    SCAN_REQ  = 2'b01,   // status read requested, no grant yet
    SCAN_WAIT = 2'b10    // granted, waiting for read data
  } scan_state_t;

endpackage

// ==== design/gpio_lite_subunit.sv ====
// GPIO register block with 16 pins.
// Holds direction, output enable and output value registers, a two stage
// input synchroniser into the input value register, and sticky rising edge
// interrupt status cleared by a status read. Reads are registered and come
// back one cycle after the read strobe.

`timescale 1ns/1ps

`include "gpio_cfg.svh"

module gpio_lite_subunit
  import gpio_bus_pkg::*;
  import gpio_pin_pkg::*;
(
  input  logic       pclk9,
  input  logic       n_reset9,           // async, active low
  input  logic       read,               // read strobe from arbiter
  input  logic       write,              // write strobe from arbiter
  input  gpio_addr_t addr,
  input  gpio_data_t wdata,
  input  pin_vec_t   pin_in,             // raw pin inputs
  input  pin_vec_t   tri_state_enable,   // test override, forces pins to Z
  output pin_vec_t   interrupt,
  output pin_vec_t   pin_oe_n,
  output pin_vec_t   pin_out,
  output gpio_data_t rdata
);

  pin_vec_t direction;      // 1 = input
  pin_vec_t out_enable;
  pin_vec_t out_value;
  pin_vec_t in_value;       // third sync stage, readable
  pin_vec_t int_status;     // sticky rising edge flags

  pin_vec_t sync_one;       // first stage, next to the pin
  pin_vec_t sync_two;

  pin_vec_t int_event;      // rising edge seen this cycle
  pin_vec_t int_trigger;    // edge on an input pin
  logic     status_clear;   // status read in progress

  // --------------------
  // address decode

  logic ad_direction;
  logic ad_out_enable;
  logic ad_out_value;
  logic ad_int_status;

  assign ad_direction  = (addr == `GPIO_ADDR_DIRECTION);
  assign ad_out_enable = (addr == `GPIO_ADDR_OUT_ENABLE);
  assign ad_out_value  = (addr == `GPIO_ADDR_OUT_VALUE);
  assign ad_int_status = (addr == `GPIO_ADDR_INT_STATUS);

  // writable registers, update at the grant edge
  always_ff @(posedge pclk9 or negedge n_reset9)
  begin
    if (!n_reset9)
    begin
      direction  <= '0;   // all outputs
      out_enable <= '0;   // all drivers off
      out_value  <= '0;
    end
    else if (write)
    begin
      if (ad_direction)
        direction <= wdata;
      if (ad_out_enable)
        out_enable <= wdata;
      if (ad_out_value)
        out_value <= wdata;
    end
  end

  // --------------------
  // input synchroniser
  // pin change reaches in_value after three edges

  always_ff @(posedge pclk9 or negedge n_reset9)
  begin
    if (!n_reset9)
    begin
      sync_one <= '0;
      sync_two <= '0;
      in_value <= '0;
    end
    else
    begin
      sync_one <= pin_in;
      sync_two <= sync_one;
      in_value <= sync_two;
    end
  end

  // rising edge = new value high, old value low
  assign int_event   = (sync_two ^ in_value) & sync_two;
  assign int_trigger = int_event & direction;   // output pins never flag
  assign status_clear = read & ad_int_status;

  // sticky status, new edges win over the clear
  always_ff @(posedge pclk9 or negedge n_reset9)
  begin
    if (!n_reset9)
      int_status <= '0;
    else
      int_status <= (int_status & ~{`GPIO_WIDTH{status_clear}}) | int_trigger;
  end

  // --------------------
  // registered read data, zero when idle

  always_ff @(posedge pclk9 or negedge n_reset9)
  begin
    if (!n_reset9)
      rdata <= '0;
    else if (read)
    begin
      case (addr)
        `GPIO_ADDR_DIRECTION:  rdata <= direction;
        `GPIO_ADDR_OUT_ENABLE: rdata <= out_enable;
        `GPIO_ADDR_OUT_VALUE:  rdata <= out_value;
        `GPIO_ADDR_INT_STATUS: rdata <= int_status;
        default:               rdata <= in_value;   // input value or unmapped
      endcase
    end
    else
      rdata <= '0;
  end

  // pin drive
  assign interrupt = int_status;
  assign pin_out   = out_value;
  assign pin_oe_n  = ~(out_enable & ~direction) | tri_state_enable;   // low = driving

  // arbiter only ever presents one strobe per cycle
  a_no_read_write : assert property (
    @(posedge pclk9) disable iff (!n_reset9) !(read && write)
  );

endmodule

// ==== design/gpio_bus_arbiter.sv ====
// Shares the single register bus between the host port and the interrupt
// scanner. Grants are combinational, round-robin on a conflict. The owner
// of each read is kept for one cycle so the returned data and its valid
// pulse go back to the master that asked.

`timescale 1ns/1ps

module gpio_bus_arbiter
  import gpio_bus_pkg::*;
(
  input  logic       pclk9,
  input  logic       n_reset9,
  // host side
  input  logic       host_read,
  input  logic       host_write,
  input  gpio_addr_t host_addr,
  input  gpio_data_t host_wdata,
  output logic       host_gnt,
  output logic       host_rvalid,
  output gpio_data_t host_rdata,
  // scanner side has no write path
  input  logic       scan_read,
  input  gpio_addr_t scan_addr,
  output logic       scan_gnt,
  output logic       scan_rvalid,
  output gpio_data_t scan_rdata,
  // register bus
  output logic       bus_read,
  output logic       bus_write,
  output gpio_addr_t bus_addr,
  output gpio_data_t bus_wdata,
  input  gpio_data_t bus_rdata
);

  bus_owner_t last_winner;   // winner of the most recent grant
  bus_owner_t rd_owner;      // who issued the read last cycle
  logic       rd_pending;    // read data due this cycle
  logic       host_req;

  assign host_req = host_read | host_write;

  // a lone request wins at once and a conflict goes to the master that lost last time
  assign host_gnt = host_req  & (~scan_read | (last_winner == OWNER_SCAN));
  assign scan_gnt = scan_read & (~host_req  | (last_winner == OWNER_HOST));

  // --------------------
  // bus mux drives an idle bus when nobody is granted

  assign bus_read  = (host_gnt & host_read) | scan_gnt;
  assign bus_write = host_gnt & host_write;
  assign bus_addr  = host_gnt ? host_addr : (scan_gnt ? scan_addr : '0);
  assign bus_wdata = host_gnt ? host_wdata : '0;

  always_ff @(posedge pclk9 or negedge n_reset9)
  begin
    if (!n_reset9)
    begin
      last_winner <= OWNER_HOST;
      rd_owner    <= OWNER_HOST;
      rd_pending  <= 1'b0;
    end
    else
    begin
      if (host_gnt)
        last_winner <= OWNER_HOST;
      else if (scan_gnt)
        last_winner <= OWNER_SCAN;
      rd_pending <= bus_read;
      if (bus_read)
        rd_owner <= scan_gnt ? OWNER_SCAN : OWNER_HOST;
    end
  end

  // read return steering
  assign host_rvalid = rd_pending & (rd_owner == OWNER_HOST);
  assign scan_rvalid = rd_pending & (rd_owner == OWNER_SCAN);
  assign host_rdata  = (rd_owner == OWNER_HOST) ? bus_rdata : '0;
  assign scan_rdata  = (rd_owner == OWNER_SCAN) ? bus_rdata : '0;

  a_one_grant : assert property (
    @(posedge pclk9) disable iff (!n_reset9) !(host_gnt && scan_gnt)
  );

  a_gnt_has_req : assert property (
    @(posedge pclk9) disable iff (!n_reset9)
      (host_gnt |-> host_req) and (scan_gnt |-> scan_read)
  );

endmodule

// ==== design/gpio_irq_scanner.sv ====
// Interrupt scanner. Whenever the register block flags a pending interrupt
// it reads the status register through the arbiter, which clears it, and
// ORs the returned bits into irq_bits. The host sees irq while any bit is
// held and clears the set with a one cycle irq_ack pulse.

`timescale 1ns/1ps

`include "gpio_cfg.svh"

module gpio_irq_scanner
  import gpio_bus_pkg::*;
  import gpio_pin_pkg::*;
(
  input  logic       pclk9,
  input  logic       n_reset9,
  input  pin_vec_t   interrupt,     // status register of the block
  input  logic       scan_gnt,
  input  logic       scan_rvalid,
  input  gpio_data_t scan_rdata,
  input  logic       irq_ack,       // host acknowledge pulse
  output logic       scan_read,
  output gpio_addr_t scan_addr,
  output pin_vec_t   irq_bits,      // latched captured edges
  output logic       irq
);

  scan_state_t state;
  scan_state_t state_nxt;
  pin_vec_t    captured;   // status bits returned this cycle

  // --------------------
  // FSM

  always_comb
  begin
    state_nxt = state;
    case (state)
      SCAN_IDLE:
        if (|interrupt)
          state_nxt = SCAN_REQ;
      SCAN_REQ:
        if (scan_gnt)
          state_nxt = SCAN_WAIT;   // read issued at this edge
      SCAN_WAIT:
        if (scan_rvalid)
          state_nxt = SCAN_IDLE;
      default:
        state_nxt = SCAN_IDLE;
    endcase
  end

  always_ff @(posedge pclk9 or negedge n_reset9)
  begin
    if (!n_reset9)
      state <= SCAN_IDLE;
    else
      state <= state_nxt;
  end

  // request held until granted, address only while requesting
  assign scan_read = (state == SCAN_REQ);
  assign scan_addr = scan_read ? `GPIO_ADDR_INT_STATUS : '0;

  // --------------------
  // captured bit set

  assign captured = (state == SCAN_WAIT && scan_rvalid) ? scan_rdata : '0;

  always_ff @(posedge pclk9 or negedge n_reset9)
  begin
    if (!n_reset9)
      irq_bits <= '0;
    else if (irq_ack)
      irq_bits <= captured;   // ack drops old bits, keeps this cycle's
    else
      irq_bits <= irq_bits | captured;
  end

  assign irq = |irq_bits;

  // read data for the scanner only after its own granted read
  a_rvalid_in_wait : assert property (
    @(posedge pclk9) disable iff (!n_reset9) scan_rvalid |-> (state == SCAN_WAIT)
  );

endmodule

// ==== design/gpio_subsystem.sv ====
// Top level of the GPIO subsystem.
// Host port and interrupt scanner share the register block's bus through
// the arbiter. Pins come out as plain vectors, no pad cells.

`timescale 1ns/1ps

module gpio_subsystem
  import gpio_bus_pkg::*;
  import gpio_pin_pkg::*;
(
  input  logic       pclk9,
  input  logic       n_reset9,
  input  logic       host_read,
  input  logic       host_write,
  input  gpio_addr_t host_addr,
  input  gpio_data_t host_wdata,
  input  logic       irq_ack,
  input  pin_vec_t   pin_in,
  input  pin_vec_t   tri_state_enable,
  output logic       host_gnt,
  output logic       host_rvalid,
  output gpio_data_t host_rdata,
  output logic       irq,
  output pin_vec_t   irq_bits,
  output pin_vec_t   pin_out,
  output pin_vec_t   pin_oe_n
);

  // scanner to arbiter
  logic       scan_read;
  gpio_addr_t scan_addr;
  logic       scan_gnt;
  logic       scan_rvalid;
  gpio_data_t scan_rdata;

  // arbiter to register block
  logic       bus_read;
  logic       bus_write;
  gpio_addr_t bus_addr;
  gpio_data_t bus_wdata;
  gpio_data_t bus_rdata;
  pin_vec_t   interrupt;   // status register, feeds the scanner

  gpio_bus_arbiter i_gpio_bus_arbiter (
    .pclk9       (pclk9),
    .n_reset9    (n_reset9),
    .host_read   (host_read),
    .host_write  (host_write),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .scan_read   (scan_read),
    .scan_addr   (scan_addr),
    .scan_gnt    (scan_gnt),
    .scan_rvalid (scan_rvalid),
    .scan_rdata  (scan_rdata),
    .bus_read    (bus_read),
    .bus_write   (bus_write),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_rdata   (bus_rdata)
  );

  gpio_irq_scanner i_gpio_irq_scanner (
    .pclk9       (pclk9),
    .n_reset9    (n_reset9),
    .interrupt   (interrupt),
    .scan_gnt    (scan_gnt),
    .scan_rvalid (scan_rvalid),
    .scan_rdata  (scan_rdata),
    .irq_ack     (irq_ack),
    .scan_read   (scan_read),
    .scan_addr   (scan_addr),
    .irq_bits    (irq_bits),
    .irq         (irq)
  );

  gpio_lite_subunit i_gpio_lite_subunit (
    .pclk9            (pclk9),
    .n_reset9         (n_reset9),
    .read             (bus_read),
    .write            (bus_write),
    .addr             (bus_addr),
    .wdata            (bus_wdata),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .interrupt        (interrupt),
    .pin_oe_n         (pin_oe_n),
    .pin_out          (pin_out),
    .rdata            (bus_rdata)
  );

endmodule

// ==== tests/gpio_subsystem_tb.sv ====
// Testbench for the GPIO subsystem.
// Builds a table of host bus operations, pin changes and interrupt checks,
// then applies it row by row to the top level. Expected values come from a
// small register model that is updated while the table is built.

`timescale 1ns/1ps

`include "gpio_cfg.svh"

module gpio_subsystem_tb
  import gpio_bus_pkg::*;
  import gpio_pin_pkg::*;
();

  localparam int TIMEOUT = 50;   // cycles per wait loop

  typedef enum logic [3:0]
  {
    OP_WRITE, OP_READ, OP_PINS, OP_TRI, OP_DRIVE,
    OP_IRQ, OP_BITS, OP_ACK, OP_STRESS, OP_RACE
  } op_t;

  typedef struct packed
  {
    op_t        op;
    gpio_addr_t addr;
    gpio_data_t data;      // write data, pin value, or expected pin_out
    gpio_data_t exp_val;   // expected read data, irq_bits or pin_oe_n
  } row_t;

  logic       pclk9, n_reset9;
  logic       host_read, host_write, irq_ack;
  gpio_addr_t host_addr;
  gpio_data_t host_wdata;
  pin_vec_t   pin_in, tri_state_enable;
  logic       host_gnt, host_rvalid, irq;
  gpio_data_t host_rdata;
  pin_vec_t   irq_bits, pin_out, pin_oe_n;

  row_t        table_rows [0:79];
  int          n_rows;
  int          n_mismatch;
  int          n_timeout;
  logic [31:0] lfsr;

  // register model used while building the table
  pin_vec_t m_dir, m_oe, m_out, m_tri, m_pins, m_bits;

  gpio_subsystem i_gpio_subsystem (.*);

  initial
  begin
    pclk9 = 1'b0;
    forever #20 pclk9 = ~pclk9;   // 40 ns period
  end

  // --------------------
  // random data

  function automatic logic lfsr_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // taps 32 22 2 1
    return lfsr[0];
  endfunction

  function automatic gpio_data_t rand_word();
    gpio_data_t w;
    w = '0;
    for (int i = 0; i < `GPIO_WIDTH; i++)
      w = {w[`GPIO_WIDTH-2:0], lfsr_bit()};   // one step per bit
    return w;
  endfunction

  // --------------------
  // table building

  function automatic void add_row(op_t op_code, gpio_addr_t a, gpio_data_t d, gpio_data_t e);
    table_rows[n_rows] = '{op_code, a, d, e};
    n_rows++;
  endfunction

  function automatic gpio_data_t reg_model(input gpio_addr_t addr);
    case (addr)
      `GPIO_ADDR_DIRECTION:  return m_dir;
      `GPIO_ADDR_OUT_ENABLE: return m_oe;
      `GPIO_ADDR_OUT_VALUE:  return m_out;
      default:               return m_pins;   // input value and unmapped
    endcase
  endfunction

  function automatic void add_write(gpio_addr_t addr, gpio_data_t data);
    if (addr == `GPIO_ADDR_DIRECTION)
      m_dir = data;
    if (addr == `GPIO_ADDR_OUT_ENABLE)
      m_oe = data;
    if (addr == `GPIO_ADDR_OUT_VALUE)
      m_out = data;
    add_row(OP_WRITE, addr, data, '0);
  endfunction

  function automatic void add_read(gpio_addr_t addr);
    add_row(OP_READ, addr, '0, reg_model(addr));
  endfunction

  function automatic void add_pins(pin_vec_t value);
    m_bits |= value & ~m_pins & m_dir;   // rising edges on inputs only
    m_pins = value;
    add_row(OP_PINS, '0, value, '0);
  endfunction

  function automatic void add_tri(pin_vec_t value);
    m_tri = value;
    add_row(OP_TRI, '0, value, '0);
  endfunction

  // pin by pin from the drive rule
  function automatic void add_drive();
    pin_vec_t oe_n;
    for (int i = 0; i < `GPIO_WIDTH; i++)
    begin
      if (m_oe[i] && !m_dir[i] && !m_tri[i])
        oe_n[i] = 1'b0;   // enabled output drives
      else
        oe_n[i] = 1'b1;
    end
    add_row(OP_DRIVE, '0, m_out, oe_n);
  endfunction

  function automatic void add_ack();
    m_bits = '0;
    add_row(OP_ACK, '0, '0, '0);
  endfunction

  task automatic build_table();
    pin_vec_t pattern;
    lfsr   = 32'h67b4_533f;
    n_rows = 0;
    {m_dir, m_oe, m_out, m_tri, m_pins, m_bits} = '0;
    // register readback
    for (int i = 0; i < 3; i++)
    begin
      add_write(`GPIO_ADDR_DIRECTION, rand_word());
      add_write(`GPIO_ADDR_OUT_ENABLE, rand_word());
      add_write(`GPIO_ADDR_OUT_VALUE, rand_word());
      add_read(`GPIO_ADDR_DIRECTION);
      add_read(`GPIO_ADDR_OUT_ENABLE);
      add_read(`GPIO_ADDR_OUT_VALUE);
    end
    // pin drive mixes
    add_drive();
    add_tri(16'h00ff);
    add_drive();
    add_write(`GPIO_ADDR_DIRECTION, 16'h0000);
    add_write(`GPIO_ADDR_OUT_ENABLE, 16'hffff);
    add_drive();
    add_tri(16'hf0f0);
    add_drive();
    add_write(`GPIO_ADDR_DIRECTION, 16'h3c3c);
    add_drive();
    add_tri(16'h0000);
    add_drive();
    // input value and unmapped address
    for (int i = 0; i < 2; i++)
    begin
      add_pins(rand_word());
      add_read(`GPIO_ADDR_IN_VALUE);
      add_read(6'h3c);
    end
    // interrupts from rising edges on inputs
    add_write(`GPIO_ADDR_DIRECTION, 16'h0ff0);
    add_pins(16'h0000);
    add_ack();
    add_pins(16'hffff);
    add_row(OP_IRQ, '0, '0, m_bits);
    add_pins(16'h0000);                  // falling edges only
    add_row(OP_BITS, '0, '0, m_bits);
    add_pins(16'hf00f);                  // rising on output pins only
    add_row(OP_BITS, '0, '0, m_bits);
    add_ack();
    // host reads under scanner traffic
    add_write(`GPIO_ADDR_DIRECTION, rand_word() | 16'h8001);
    add_pins(16'h0000);
    add_ack();
    add_row(OP_STRESS, '0, m_dir, m_dir);   // every pin rises once
    m_pins = 16'hffff;
    // host and scanner both read status
    for (int i = 0; i < 2; i++)
    begin
      add_pins(16'h0000);
      add_ack();
      add_write(`GPIO_ADDR_DIRECTION, rand_word() | 16'h0410);
      pattern = rand_word() | 16'h0410;
      add_row(OP_RACE, '0, pattern, pattern & m_dir);
      m_pins = pattern;
    end
    add_pins(16'h0000);
    add_ack();
  endtask

  // --------------------
  // checks and bus tasks

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      n_mismatch++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge pclk9);
  endtask

  // one host access that starts and ends on a falling edge
  task automatic bus_access(input logic wr, input gpio_addr_t addr, input gpio_data_t data,
                            output gpio_data_t rd);
    int   t;
    logic granted;
    host_read  = !wr;
    host_write = wr;
    host_addr  = addr;
    host_wdata = data;
    t       = 0;
    granted = 1'b0;
    while (!granted && t < TIMEOUT)
    begin
      #5;                   // grant is combinational and settled well before the edge
      granted = host_gnt;
      @(negedge pclk9);     // grant edge passes in between
      t++;
    end
    host_read  = 1'b0;
    host_write = 1'b0;
    assert (granted)
    else
    begin
      n_timeout++;
      $display("host access to address %h was never granted", addr);
    end
    rd = '0;
    if (!wr)
    begin
      t = 0;
      while (!host_rvalid && t < TIMEOUT)
      begin
        @(negedge pclk9);
        t++;
      end
      assert (host_rvalid)
      else
      begin
        n_timeout++;
        $display("no read data returned for address %h", addr);
      end
      rd = host_rdata;
    end
  endtask

  task automatic wait_irq();
    int t;
    t = 0;
    while (!irq && t < TIMEOUT)
    begin
      @(negedge pclk9);
      t++;
    end
    assert (irq)
    else
    begin
      n_timeout++;
      $display("irq never went high");
    end
  endtask

  task automatic pulse_ack();
    irq_ack = 1'b1;
    @(negedge pclk9);
    irq_ack = 1'b0;
    check_value("irq_bits", irq_bits, '0);
    check_value("irq", irq, 1'b0);
  endtask

  // host keeps reading direction while each pin rises in turn
  task automatic arbitration_stress(input gpio_data_t dir_val, input pin_vec_t exp_bits);
    gpio_data_t rd;
    int         t;
    for (int i = 0; i < `GPIO_WIDTH; i++)
    begin
      pin_in[i] = 1'b1;
      bus_access(1'b0, `GPIO_ADDR_DIRECTION, '0, rd);
      check_value("host_rdata", rd, dir_val);
    end
    t = 0;
    while (irq_bits !== exp_bits && t < TIMEOUT)
    begin
      @(negedge pclk9);
      t++;
    end
    check_value("irq_bits", irq_bits, exp_bits);
  endtask

  // host status reads compete with the scanner for the same edges
  task automatic status_race(input pin_vec_t pattern, input pin_vec_t exp_bits);
    gpio_data_t rd;
    gpio_data_t host_seen;
    int         t;
    host_seen = '0;
    pin_in    = pattern;
    for (int i = 0; i < 6; i++)
    begin
      bus_access(1'b0, `GPIO_ADDR_INT_STATUS, '0, rd);
      host_seen |= rd;
    end
    t = 0;
    while ((host_seen | irq_bits) !== exp_bits && t < TIMEOUT)
    begin
      @(negedge pclk9);
      t++;
    end
    check_value("host status | irq_bits", host_seen | irq_bits, exp_bits);
    check_value("host status & irq_bits", host_seen & irq_bits, '0);   // each edge seen once
  endtask

  // --------------------
  // main sequence

  initial
  begin
    row_t       row;
    gpio_data_t rd;
    n_mismatch       = 0;
    n_timeout        = 0;
    n_reset9         = 1'b0;
    host_read        = 1'b0;
    host_write       = 1'b0;
    host_addr        = '0;
    host_wdata       = '0;
    irq_ack          = 1'b0;
    pin_in           = '0;
    tri_state_enable = '0;
    build_table();
    wait_cycles(2);   // reset for two cycles
    check_value("pin_oe_n", pin_oe_n, 16'hffff);
    check_value("pin_out", pin_out, '0);
    check_value("irq_bits", irq_bits, '0);
    check_value("irq", irq, 1'b0);
    check_value("host_gnt", host_gnt, 1'b0);
    check_value("host_rvalid", host_rvalid, 1'b0);
    n_reset9 = 1'b1;
    for (int r = 0; r < n_rows; r++)
    begin
      row = table_rows[r];
      case (row.op)
        OP_WRITE:
          bus_access(1'b1, row.addr, row.data, rd);
        OP_READ:
        begin
          bus_access(1'b0, row.addr, '0, rd);
          check_value("host_rdata", rd, row.exp_val);
        end
        OP_PINS:
        begin
          pin_in = row.data;
          wait_cycles(10);   // past sync stages and one scan
        end
        OP_TRI:
        begin
          tri_state_enable = row.data;
          wait_cycles(1);
        end
        OP_DRIVE:
        begin
          check_value("pin_out", pin_out, row.data);
          check_value("pin_oe_n", pin_oe_n, row.exp_val);
        end
        OP_IRQ:
        begin
          wait_irq();
          check_value("irq_bits", irq_bits, row.exp_val);
        end
        OP_BITS:
        begin
          check_value("irq_bits", irq_bits, row.exp_val);
          check_value("irq", irq, row.exp_val != '0);
        end
        OP_ACK:
          pulse_ack();
        OP_STRESS:
          arbitration_stress(row.data, row.exp_val);
        OP_RACE:
          status_race(row.data, row.exp_val);
        default:
          ;
      endcase
    end
    $display("errors: %0d mismatches, %0d timeouts", n_mismatch, n_timeout);
    if (n_mismatch == 0 && n_timeout == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+design
design/gpio_bus_pkg.sv
design/gpio_pin_pkg.sv
design/gpio_lite_subunit.sv
design/gpio_bus_arbiter.sv
design/gpio_irq_scanner.sv
design/gpio_subsystem.sv
tests/gpio_subsystem_tb.sv
